// File: rtl/cache_geom_pkg.sv
package cache_geom_pkg;

  localparam int ADDR_W      = 32;
  localparam int INST_W      = 32;
  localparam int BLOCK_W     = 64;
  localparam int OFFSET_W    = 3;                  // byte offset in a line
  localparam int INDEX_W     = 5;
  localparam int TAG_W       = 8;                  // address bits 15 to 8
  localparam int LINES       = 1 << INDEX_W;
  localparam int BLOCK_BYTES = 1 << OFFSET_W;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [INST_W-1:0]  inst_t;
  typedef logic [BLOCK_W-1:0] block_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0]   tag_t;

endpackage

// File: rtl/mem_bus_pkg.sv
package mem_bus_pkg;

  // transaction tag handed out by the memory
  typedef logic [3:0] mem_tag_t;

  localparam mem_tag_t NO_TAG = 4'd0;              // load not accepted

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_e;

endpackage

// File: rtl/fetch_window.sv
`timescale 1ns/100ps

module fetch_window
  import cache_geom_pkg::*;
#(
  parameter int LANES = 3
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              take_branch,
  input  addr_t             branch_target,
  input  logic [LANES-1:0]  lane_valid,
  output addr_t             fetch_pc,
  output addr_t [LANES-1:0] lane_addr
);

  localparam int RUN_W = $clog2(LANES + 1);

  logic [RUN_W-1:0] run;                           // leading valid lanes
  addr_t            pc_next;

  always_comb begin
    logic stop;
    stop = 1'b0;
    run  = '0;
    for (int k = 0; k < LANES; k++) begin
      if (!stop && lane_valid[k]) begin
        run = run + 1'b1;
      end else begin
        stop = 1'b1;                               // first gap ends the run
      end
    end
  end

  assign pc_next = take_branch ? branch_target : fetch_pc + (addr_t'(run) << 2);

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc <= '0;
    end else begin
      fetch_pc <= pc_next;
    end
  end

  for (genvar k = 0; k < LANES; k++) begin : g_addr
    assign lane_addr[k] = fetch_pc + addr_t'(4 * k);
  end

endmodule

// File: rtl/icache_lane.sv
`timescale 1ns/100ps

module icache_lane
  import cache_geom_pkg::*;
(
  input  addr_t  addr,
  output index_t rd_index,
  input  tag_t   rd_tag,
  input  logic   rd_valid,
  input  block_t rd_block,
  output inst_t  inst,
  output logic   inst_valid
);

  tag_t addr_tag;

  assign rd_index = addr[OFFSET_W +: INDEX_W];
  assign addr_tag = addr[OFFSET_W + INDEX_W +: TAG_W];

  // hit only when the stored line belongs to this address
  assign inst_valid = rd_valid && (rd_tag == addr_tag);

  // bit 2 picks the word inside the line
  assign inst = addr[OFFSET_W-1] ? rd_block[BLOCK_W-1 -: INST_W]
                                 : rd_block[INST_W-1:0];

endmodule

// File: rtl/icache_data.sv
`timescale 1ns/100ps

module icache_data
  import cache_geom_pkg::*;
#(
  parameter int LANES = 3
) (
  input  logic               clock,
  input  logic               reset,
  input  index_t [LANES-1:0] rd_index,
  output tag_t   [LANES-1:0] rd_tag,
  output logic   [LANES-1:0] rd_valid,
  output block_t [LANES-1:0] rd_block,
  input  logic               wr_en,
  input  index_t             wr_index,
  input  tag_t               wr_tag,
  input  block_t             wr_block,
  input  logic               flush
);

  tag_t             tags   [LINES];
  block_t           blocks [LINES];
  logic [LINES-1:0] valid;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      tags[wr_index]   <= wr_tag;
      blocks[wr_index] <= wr_block;
    end
  end

  for (genvar k = 0; k < LANES; k++) begin : g_read
    assign rd_tag[k]   = tags[rd_index[k]];        // async read port
    assign rd_valid[k] = valid[rd_index[k]];
    assign rd_block[k] = blocks[rd_index[k]];
  end

endmodule

// File: rtl/icache_prefetch.sv
`timescale 1ns/100ps

module icache_prefetch
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int PREF = 4
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         branch,
  input  logic         give_way,
  input  logic         want_to_fetch,
  input  addr_t        miss_addr,
  input  mem_tag_t     mem_response,
  input  mem_tag_t     mem_tag,
  output logic         already_fetched,
  output bus_command_e pref_command,
  output addr_t        pref_addr,
  output logic         pref_wr_en,
  output index_t       pref_index,
  output tag_t         pref_tag
);

  localparam int CNT_W = $clog2(PREF + 1);

  typedef enum logic {
    PF_IDLE,
    PF_STREAM
  } pf_state_e;

  pf_state_e        state;
  addr_t            next_addr;                     // next block to request
  addr_t            stream_base;                   // miss that started the stream
  logic [CNT_W-1:0] remaining;
  logic [PREF-1:0]  slot_valid;
  mem_tag_t         slot_tag  [PREF];
  addr_t            slot_addr [PREF];
  logic [PREF-1:0]  slot_hit;
  logic [PREF-1:0]  slot_free;                     // lowest free slot, one-hot
  addr_t            hit_addr;
  logic             start;
  logic             accept;
  logic             last_block;

  always_comb begin
    logic taken;
    taken           = 1'b0;
    already_fetched = 1'b0;
    hit_addr        = '0;
    for (int s = 0; s < PREF; s++) begin
      slot_hit[s]  = slot_valid[s] && (slot_tag[s] == mem_tag);
      slot_free[s] = !slot_valid[s] && !taken;
      taken        = taken || !slot_valid[s];
      if (slot_hit[s]) begin
        hit_addr = slot_addr[s];
      end
      if (slot_valid[s] && (slot_addr[s] == miss_addr)) begin
        already_fetched = 1'b1;
      end
    end
  end

  assign pref_wr_en = |slot_hit;
  assign pref_index = hit_addr[OFFSET_W +: INDEX_W];
  assign pref_tag   = hit_addr[OFFSET_W + INDEX_W +: TAG_W];

  assign pref_command = (state == PF_STREAM && |slot_free && !branch) ? BUS_LOAD : BUS_NONE;
  assign pref_addr    = next_addr;

  assign accept = (pref_command == BUS_LOAD) && !give_way && (mem_response != NO_TAG);
  assign start  = want_to_fetch && !already_fetched && (miss_addr != stream_base);

  // stream never leaves the tag page of the miss
  assign last_block = (remaining == CNT_W'(1)) || (next_addr[OFFSET_W +: INDEX_W] == '1);

  always_ff @(posedge clock) begin
    if (reset || branch) begin
      state       <= PF_IDLE;
      slot_valid  <= '0;                           // late returns now match nothing
      stream_base <= '1;
      remaining   <= '0;
    end else begin
      slot_valid <= (slot_valid & ~slot_hit) | (accept ? slot_free : '0);
      if (start) begin
        stream_base <= miss_addr;
        remaining   <= CNT_W'(PREF);
        state       <= (miss_addr[OFFSET_W +: INDEX_W] == '1) ? PF_IDLE : PF_STREAM;
      end else if (accept) begin
        remaining <= remaining - 1'b1;
        if (last_block) begin
          state <= PF_IDLE;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      next_addr <= miss_addr + addr_t'(BLOCK_BYTES);
    end else if (accept) begin
      next_addr <= next_addr + addr_t'(BLOCK_BYTES);
    end
    for (int s = 0; s < PREF; s++) begin
      if (accept && slot_free[s]) begin
        slot_tag[s]  <= mem_response;
        slot_addr[s] <= next_addr;
      end
    end
  end

endmodule

// File: rtl/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int LANES = 3
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              take_branch,
  input  logic              dcache_request,
  input  addr_t [LANES-1:0] lane_addr,
  input  logic [LANES-1:0]  lane_valid,
  input  mem_tag_t          mem_response,
  input  mem_tag_t          mem_tag,
  output bus_command_e      mem_command,
  output addr_t             mem_addr,
  output logic              give_way,
  output logic              want_to_fetch,
  output addr_t             miss_addr,
  input  logic              already_fetched,
  input  bus_command_e      pref_command,
  input  addr_t             pref_addr,
  input  logic              pref_wr_en,
  input  index_t            pref_index,
  input  tag_t              pref_tag,
  output logic              wr_en,
  output index_t            wr_index,
  output tag_t              wr_tag
);

  logic     armed;                                 // low until one cycle after reset
  mem_tag_t bus_response;
  mem_tag_t demand_tag;                            // accepted demand load in flight
  addr_t    demand_addr;
  logic     require_load;
  logic     accepted;
  logic     demand_wr;

  assign bus_response = dcache_request ? NO_TAG : mem_response;  // dcache took the bus

  // block of the first lane that missed
  always_comb begin
    logic found;
    found     = 1'b0;
    miss_addr = '0;
    for (int k = 0; k < LANES; k++) begin
      if (!found && !lane_valid[k]) begin
        found     = 1'b1;
        miss_addr = lane_addr[k] & ~addr_t'(BLOCK_BYTES - 1);
      end
    end
  end

  assign want_to_fetch = armed && !(&lane_valid);
  assign require_load  = want_to_fetch && !already_fetched &&
                         (demand_tag == NO_TAG || miss_addr != demand_addr);
  assign accepted      = require_load && (bus_response != NO_TAG) && !take_branch;
  assign give_way      = require_load || dcache_request;
  assign demand_wr     = (demand_tag != NO_TAG) && (mem_tag == demand_tag);

  always_comb begin
    if (require_load) begin
      mem_command = BUS_LOAD;                      // demand beats prefetch
      mem_addr    = miss_addr;
    end else if (pref_command == BUS_LOAD) begin
      mem_command = BUS_LOAD;
      mem_addr    = pref_addr;
    end else begin
      mem_command = BUS_NONE;
      mem_addr    = '0;
    end
  end

  assign wr_en    = demand_wr || pref_wr_en;
  assign wr_index = demand_wr ? demand_addr[OFFSET_W +: INDEX_W] : pref_index;
  assign wr_tag   = demand_wr ? demand_addr[OFFSET_W + INDEX_W +: TAG_W] : pref_tag;

  always_ff @(posedge clock) begin
    if (reset) begin
      armed      <= 1'b0;
      demand_tag <= NO_TAG;
    end else begin
      armed <= 1'b1;
      if (take_branch) begin
        demand_tag <= NO_TAG;                      // old path return is dropped
      end else if (accepted) begin
        demand_tag <= bus_response;
      end else if (demand_wr) begin
        demand_tag <= NO_TAG;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accepted) begin
      demand_addr <= miss_addr;
    end
  end

endmodule

// File: rtl/icache_top.sv
`timescale 1ns/100ps

module icache_top
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int LANES = 3,
  parameter int PREF  = 4
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              take_branch,
  input  addr_t             branch_target,
  input  logic              dcache_request,
  input  mem_tag_t          mem_response,
  input  block_t            mem_data,
  input  mem_tag_t          mem_tag,
  output bus_command_e      mem_command,
  output addr_t             mem_addr,
  output addr_t             fetch_pc,
  output inst_t [LANES-1:0] inst,
  output logic [LANES-1:0]  inst_valid
);

  addr_t  [LANES-1:0] lane_addr;
  index_t [LANES-1:0] rd_index;
  tag_t   [LANES-1:0] rd_tag;
  logic   [LANES-1:0] rd_valid;
  block_t [LANES-1:0] rd_block;
  logic               wr_en;
  index_t             wr_index;
  tag_t               wr_tag;
  logic               give_way;
  logic               want_to_fetch;
  addr_t              miss_addr;
  logic               already_fetched;
  bus_command_e       pref_command;
  addr_t              pref_addr;
  logic               pref_wr_en;
  index_t             pref_index;
  tag_t               pref_tag;

  fetch_window #(.LANES(LANES)) fetch_window_i (
    .clock         (clock),
    .reset         (reset),
    .take_branch   (take_branch),
    .branch_target (branch_target),
    .lane_valid    (inst_valid),
    .fetch_pc      (fetch_pc),
    .lane_addr     (lane_addr)
  );

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    icache_lane icache_lane_i (
      .addr       (lane_addr[k]),
      .rd_index   (rd_index[k]),
      .rd_tag     (rd_tag[k]),
      .rd_valid   (rd_valid[k]),
      .rd_block   (rd_block[k]),
      .inst       (inst[k]),
      .inst_valid (inst_valid[k])
    );
  end

  icache_data #(.LANES(LANES)) icache_data_i (
    .clock    (clock),
    .reset    (reset),
    .rd_index (rd_index),
    .rd_tag   (rd_tag),
    .rd_valid (rd_valid),
    .rd_block (rd_block),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_tag   (wr_tag),
    .wr_block (mem_data),                          // every fill comes off the bus
    .flush    (1'b0)                               // code is never modified
  );

  icache_ctrl #(.LANES(LANES)) icache_ctrl_i (
    .clock           (clock),
    .reset           (reset),
    .take_branch     (take_branch),
    .dcache_request  (dcache_request),
    .lane_addr       (lane_addr),
    .lane_valid      (inst_valid),
    .mem_response    (mem_response),
    .mem_tag         (mem_tag),
    .mem_command     (mem_command),
    .mem_addr        (mem_addr),
    .give_way        (give_way),
    .want_to_fetch   (want_to_fetch),
    .miss_addr       (miss_addr),
    .already_fetched (already_fetched),
    .pref_command    (pref_command),
    .pref_addr       (pref_addr),
    .pref_wr_en      (pref_wr_en),
    .pref_index      (pref_index),
    .pref_tag        (pref_tag),
    .wr_en           (wr_en),
    .wr_index        (wr_index),
    .wr_tag          (wr_tag)
  );

  icache_prefetch #(.PREF(PREF)) icache_prefetch_i (
    .clock           (clock),
    .reset           (reset),
    .branch          (take_branch),
    .give_way        (give_way),
    .want_to_fetch   (want_to_fetch),
    .miss_addr       (miss_addr),
    .mem_response    (mem_response),
    .mem_tag         (mem_tag),
    .already_fetched (already_fetched),
    .pref_command    (pref_command),
    .pref_addr       (pref_addr),
    .pref_wr_en      (pref_wr_en),
    .pref_index      (pref_index),
    .pref_tag        (pref_tag)
  );

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 16,
  parameter int DRIVE_DELAY  = 10
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #(DRIVE_DELAY) reset = 1'b0;                   // released like any other input
  end

endmodule

// File: testbench/mem_model.sv
`timescale 1ns/100ps

module mem_model
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int WORDS       = 64,
  parameter int DRIVE_DELAY = 10
) (
  input  logic              clock,
  input  logic              reset,
  input  inst_t [WORDS-1:0] image,
  input  bus_command_e      mem_command,
  input  addr_t             mem_addr,
  output mem_tag_t          mem_response,
  output mem_tag_t          mem_tag,
  output block_t            mem_data
);

  mem_tag_t    next_tag    = 4'd1;
  logic [15:0] busy        = '0;                   // tags still waiting to return
  int          cycle_count = 0;
  mem_tag_t    ret_tag     = NO_TAG;
  block_t      ret_data    = '0;
  mem_tag_t    pend_tag  [$];
  addr_t       pend_addr [$];
  int          pend_due  [$];

  // a load is refused only while its tag would still be in flight
  assign mem_response = (mem_command === BUS_LOAD && !busy[next_tag]) ? next_tag : NO_TAG;
  assign mem_tag      = ret_tag;
  assign mem_data     = ret_data;

  function automatic block_t read_block(addr_t a);
    int b;
    b = (a >> OFFSET_W) % (WORDS / 2);
    return {image[2*b+1], image[2*b]};             // upper word at bit 2 set
  endfunction

  always @(posedge clock) begin
    mem_tag_t tag;
    addr_t    addr;
    logic     in_reset;
    int       pick;
    tag      = mem_response;                       // what the DUT saw this cycle
    addr     = mem_addr;
    in_reset = reset;
    #(DRIVE_DELAY);
    ret_tag  = NO_TAG;
    ret_data = '0;
    if (in_reset) begin
      pend_tag.delete();
      pend_addr.delete();
      pend_due.delete();
      busy     = '0;
      next_tag = 4'd1;
    end else begin
      cycle_count++;
      if (tag != NO_TAG) begin
        pend_tag.push_back(tag);
        pend_addr.push_back(addr);
        pend_due.push_back(cycle_count + 3 + int'($urandom % 6));   // 3 to 8 cycles
        busy[tag] = 1'b1;
        next_tag  = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
      pick = -1;
      for (int i = 0; i < pend_due.size(); i++) begin
        if (pick < 0 && pend_due[i] <= cycle_count) begin
          pick = i;                                // oldest due load first
        end
      end
      if (pick >= 0) begin
        ret_tag  = pend_tag[pick];
        ret_data = read_block(pend_addr[pick]);
        busy[ret_tag] = 1'b0;
        pend_tag.delete(pick);
        pend_addr.delete(pick);
        pend_due.delete(pick);
      end
    end
  end

endmodule

// File: testbench/icache_tb.sv
`timescale 1ns/100ps

module icache_tb
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
();

  localparam int LANES        = 3;
  localparam int WORDS        = 64;
  localparam int IMAGE_BYTES  = WORDS * 4;
  localparam int STIM_DEPTH   = 128;
  localparam int COUNT_AT     = 64;                // instruction total in the input file
  localparam int SCRIPT_AT    = 65;                // first cycle / target pair
  localparam int DRIVE_DELAY  = 10;
  localparam int SAMPLE_DELAY = 30;

  logic              clock;
  logic              reset;
  logic              take_branch;
  addr_t             branch_target;
  logic              dcache_request;
  mem_tag_t          mem_response;
  block_t            mem_data;
  mem_tag_t          mem_tag;
  bus_command_e      mem_command;
  addr_t             mem_addr;
  addr_t             fetch_pc;
  inst_t [LANES-1:0] inst;
  logic [LANES-1:0]  inst_valid;
  inst_t [WORDS-1:0] image;

  logic [31:0] stim [STIM_DEPTH];
  int          errors;
  int          delivered;
  int          loads;
  int          expected_total;
  int          cycle_limit;
  int          script_len;
  int          script_pos;
  int          run_cycle;                          // cycles since reset release
  int          round_base;
  addr_t       exp_pc;
  logic        reset_seen;                         // reset at the last sample
  logic        after_branch;
  logic        timed_out;

  clock_gen clock_gen_i (
    .clock (clock),
    .reset (reset)
  );

  icache_top #(.LANES(LANES), .PREF(4)) icache_top_i (
    .clock          (clock),
    .reset          (reset),
    .take_branch    (take_branch),
    .branch_target  (branch_target),
    .dcache_request (dcache_request),
    .mem_response   (mem_response),
    .mem_data       (mem_data),
    .mem_tag        (mem_tag),
    .mem_command    (mem_command),
    .mem_addr       (mem_addr),
    .fetch_pc       (fetch_pc),
    .inst           (inst),
    .inst_valid     (inst_valid)
  );

  mem_model #(.WORDS(WORDS), .DRIVE_DELAY(DRIVE_DELAY)) mem_model_i (
    .clock        (clock),
    .reset        (reset),
    .image        (image),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_tag      (mem_tag),
    .mem_data     (mem_data)
  );

  function automatic int leading_valid(logic [LANES-1:0] v);
    int n;
    n = 0;
    while (n < LANES && v[n] === 1'b1) begin
      n++;
    end
    return n;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic load_stimulus();
    for (int i = 0; i < STIM_DEPTH; i++) begin
      stim[i] = '0;
    end
    $readmemh("testbench/icache_input.txt", stim);
    for (int i = 0; i < WORDS; i++) begin
      image[i] = stim[i];
    end
    expected_total = stim[COUNT_AT];
    script_len     = 0;
    while (SCRIPT_AT + 2 * script_len + 1 < STIM_DEPTH &&
           stim[SCRIPT_AT + 2 * script_len] != 0) begin
      script_len++;
    end
    cycle_limit = 40 * expected_total + 200;
  endtask

  // the branch script replays in rounds until the run ends
  task automatic drive_cycle();
    take_branch    = 1'b0;
    dcache_request = ($urandom % 4) == 0;
    if (run_cycle - round_base == stim[SCRIPT_AT + 2 * script_pos]) begin
      take_branch   = 1'b1;
      branch_target = stim[SCRIPT_AT + 2 * script_pos + 1];
      script_pos++;
      if (script_pos == script_len) begin
        script_pos = 0;
        round_base = run_cycle;
      end
    end
  endtask

  task automatic check_cycle();
    int    run;
    addr_t lane;
    if (reset || reset_seen) begin                 // reset and the cycle after it
      if (mem_command !== BUS_NONE) begin
        report_error($sformatf("bus command %0d around reset", mem_command));
      end
      if (inst_valid !== '0) begin
        report_error($sformatf("inst_valid %b around reset", inst_valid));
      end
    end
    if (reset) begin
      exp_pc = '0;
      return;
    end
    if (fetch_pc !== exp_pc) begin
      report_error($sformatf("fetch_pc %h, expected %h%s", fetch_pc, exp_pc,
                             after_branch ? " after a branch" : ""));
    end
    for (int k = 0; k < LANES; k++) begin
      lane = exp_pc + addr_t'(4 * k);
      if (inst_valid[k] === 1'b1) begin
        if (lane >= IMAGE_BYTES) begin
          report_error($sformatf("lane %0d valid at %h outside the image", k, lane));
        end else if (inst[k] !== stim[lane >> 2]) begin
          report_error($sformatf("lane %0d at %h shows %h, expected %h",
                                 k, lane, inst[k], stim[lane >> 2]));
        end
      end
    end
    if (mem_command === BUS_LOAD) begin
      loads++;
      if (mem_addr[OFFSET_W-1:0] != 0 || mem_addr >= IMAGE_BYTES) begin
        report_error($sformatf("load address %h unaligned or outside the image", mem_addr));
      end
    end else if (mem_command !== BUS_NONE) begin
      report_error($sformatf("unexpected bus command %0d", mem_command));
    end
    run          = leading_valid(inst_valid);
    after_branch = take_branch;
    if (take_branch) begin
      exp_pc = branch_target;                      // lanes of this cycle are dropped
    end else begin
      exp_pc    = exp_pc + addr_t'(4 * run);
      delivered = delivered + run;
    end
  endtask

  initial begin
    int seed;
    seed = 70;
    void'($urandom(seed));
    take_branch    = 1'b0;
    branch_target  = '0;
    dcache_request = 1'b0;
    errors         = 0;
    delivered      = 0;
    loads          = 0;
    script_pos     = 0;
    run_cycle      = 0;
    round_base     = 0;
    exp_pc         = '0;
    reset_seen     = 1'b1;
    after_branch   = 1'b0;
    timed_out      = 1'b0;
    load_stimulus();
    if (expected_total == 0 || script_len == 0) begin
      $display("testbench/icache_input.txt is missing its instruction total or branch script");
      errors++;
    end else begin
      while (delivered < expected_total && !timed_out) begin
        @(posedge clock);
        #(DRIVE_DELAY);
        if (!reset_seen) begin
          run_cycle++;
          drive_cycle();
        end
        #(SAMPLE_DELAY);
        check_cycle();
        reset_seen = reset;
        if (run_cycle >= cycle_limit) begin
          timed_out = 1'b1;
        end
      end
    end
    if (timed_out) begin
      $display("timeout: only %0d of %0d instructions delivered after %0d cycles",
               delivered, expected_total, run_cycle);
    end
    $display("%0d errors; %0d of %0d instructions delivered in %0d cycles, %0d loads",
             errors, delivered, expected_total, run_cycle, loads);
    if (errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
rtl/cache_geom_pkg.sv
rtl/mem_bus_pkg.sv
rtl/fetch_window.sv
rtl/icache_lane.sv
rtl/icache_data.sv
rtl/icache_prefetch.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
testbench/clock_gen.sv
testbench/mem_model.sv
testbench/icache_tb.sv

// File: testbench/icache_input.txt
// memory image, 8 words per line, word i at byte address 4*i (64 words)
// then at @40 the instruction total, then branch script lines: cycle after reset, target
005aa500 015aa501 025aa502 035aa503 045aa504 055aa505 065aa506 075aa507
085aa508 095aa509 0a5aa50a 0b5aa50b 0c5aa50c 0d5aa50d 0e5aa50e 0f5aa50f
105aa510 115aa511 125aa512 135aa513 145aa514 155aa515 165aa516 175aa517
185aa518 195aa519 1a5aa51a 1b5aa51b 1c5aa51c 1d5aa51d 1e5aa51e 1f5aa51f
205aa520 215aa521 225aa522 235aa523 245aa524 255aa525 265aa526 275aa527
285aa528 295aa529 2a5aa52a 2b5aa52b 2c5aa52c 2d5aa52d 2e5aa52e 2f5aa52f
305aa530 315aa531 325aa532 335aa533 345aa534 355aa535 365aa536 375aa537
385aa538 395aa539 3a5aa53a 3b5aa53b 3c5aa53c 3d5aa53d 3e5aa53e 3f5aa53f
// instruction total
@40
0000012c
// branch script, cycles counted within a round, 0 0 ends it
00000008 00000024
00000010 00000090
00000018 00000040
00000020 00000008
00000028 0000007c
00000030 00000000
00000000 00000000
